//--- rv_multicycle_core.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/instr_decoder.sv
design/reg_file.sv
design/control_fsm.sv
design/decode_stage.sv
design/alu.sv
design/datapath.sv
design/rv_multicycle_core.sv
bench/core_checker.sv
bench/core_tb.sv

//--- bench/core_tb.sv
`include "rv_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module core_tb;

  logic        clk;
  logic        rst_n;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_we;
  logic [31:0] mem_rdata;

  logic [31:0] mem [0:255];
  logic [31:0] ref_mem [0:255];
  logic [31:0] ref_regs [0:31];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          exp_cycle [$];
  int          ref_cycle;
  bit          ref_done;
  int          cycle_cnt;
  int          errors;
  int          limit_cycles;
  int          prog_len;
  int          st_off;
  logic [31:0] rng;
  logic [2:0]  calc_f3 [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};

  rv_multicycle_core dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .mem_rdata (mem_rdata)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  assign mem_rdata = mem[mem_addr[9:2]];  // Same-cycle read

  always @(posedge clk) begin
    if (mem_we) mem[mem_addr[9:2]] <= mem_wdata;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) cycle_cnt <= 0;
    else        cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] calc(input logic [2:0] f3, input logic sub,
                                       input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // Executes one instruction of the reference copy, returns the next PC
  function automatic logic [31:0] ref_step(input logic [31:0] pc);
    logic [31:0] ins, a, b, ii, si, bi, ji, res, ea, nxt;
    logic        wr;
    ins = ref_mem[pc[9:2]];
    a   = ref_regs[ins[19:15]];
    b   = ref_regs[ins[24:20]];
    ii  = {{20{ins[31]}}, ins[31:20]};
    si  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    bi  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    ji  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    wr  = 1'b0;
    res = '0;
    nxt = pc + 4;
    case (ins[6:0])
      7'h37: begin
        res = {ins[31:12], 12'h000};
        wr  = 1'b1;
        ref_cycle += 4;
      end
      7'h6f: begin
        res = pc + 4;
        wr  = 1'b1;
        nxt = pc + ji;
        if (ji == 0) ref_done = 1'b1;  // Self-loop ends the program
        ref_cycle += 4;
      end
      7'h63: begin
        if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
          nxt = pc + bi;
        end
        ref_cycle += 3;
      end
      7'h03: begin
        ea  = a + ii;
        res = ref_mem[ea[9:2]];
        wr  = 1'b1;
        ref_cycle += 5;
      end
      7'h23: begin
        ea = a + si;
        ref_mem[ea[9:2]] = b;
        exp_addr.push_back(ea);
        exp_data.push_back(b);
        exp_cycle.push_back(ref_cycle + 3);
        ref_cycle += 4;
      end
      7'h13: begin
        res = calc(ins[14:12], 1'b0, a, ii);
        wr  = 1'b1;
        ref_cycle += 4;
      end
      7'h33: begin
        res = calc(ins[14:12], ins[30], a, b);
        wr  = 1'b1;
        ref_cycle += 4;
      end
      default: ref_cycle += 2;
    endcase
    if (wr && ins[11:7] != 0) ref_regs[ins[11:7]] = res;
    return nxt;
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[prog_len] = w;
    prog_len++;
  endtask

  task automatic op_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [11:0] imm);
    emit({imm, rs1, f3, rd, 7'h13});
  endtask

  task automatic op_r(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                      input logic [4:0] rs1, input logic [4:0] rs2);
    emit({1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'h33});
  endtask

  // SW rs2 into the next result slot above x10
  task automatic store(input logic [4:0] rs2);
    logic [11:0] off;
    off = st_off[11:0];
    emit({off[11:5], rs2, 5'd10, 3'b010, off[4:0], 7'h23});
    st_off += 4;
  endtask

  task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
    emit({1'b0, 6'd0, rs2, rs1, f3, 4'd4, 1'b0, 7'h63});  // Skip one instruction
    store(5'd7);
    store(5'd8);
  endtask

  task automatic random_reg(input logic [4:0] rd);
    rng = lcg_next(rng);
    emit({rng[31:12], rd, 7'h37});
    rng = lcg_next(rng);
    op_i(3'b000, rd, rd, rng[27:16]);
  endtask

  initial begin
    logic [31:0] pc;
    rst_n  = 1'b0;
    errors = 0;
    rng    = 32'hcc94_51d3;
    limit_cycles = 0;
    prog_len = 0;
    st_off   = 0;
    for (int i = 0; i < 256; i++) mem[i] = 32'h3c5a_0000 ^ (i * 32'h0101_0107);
    // Known prefix for the store timing
    op_i(3'b000, 5'd10, 5'd0, 12'h200);
    emit({20'hab5c3, 5'd1, 7'h37});
    store(5'd1);
    for (int r = 0; r < 3; r++) begin
      random_reg(5'd2);
      random_reg(5'd3);
      op_r(3'b000, 1'b0, 5'd4, 5'd2, 5'd3);
      store(5'd4);
      op_r(3'b000, 1'b1, 5'd4, 5'd2, 5'd3);
      store(5'd4);
      op_r(3'b010, 1'b0, 5'd4, 5'd2, 5'd3);
      store(5'd4);
      op_r(3'b010, 1'b0, 5'd4, 5'd3, 5'd2);
      store(5'd4);
      op_r(3'b100, 1'b0, 5'd4, 5'd2, 5'd3);
      store(5'd4);
      op_r(3'b110, 1'b0, 5'd4, 5'd2, 5'd3);
      store(5'd4);
      op_r(3'b111, 1'b0, 5'd4, 5'd2, 5'd3);
      store(5'd4);
      foreach (calc_f3[k]) begin
        rng = lcg_next(rng);
        op_i(calc_f3[k], 5'd4, 5'd2, rng[23:12]);
        store(5'd4);
      end
    end
    // SW/LW round trip, then a load of untouched memory
    store(5'd3);
    emit({st_off[11:0] - 12'd4, 5'd10, 3'b010, 5'd5, 7'h03});  // LW x5 from the last slot
    store(5'd5);
    emit({12'h3f0, 5'd0, 3'b010, 5'd6, 7'h03});
    store(5'd6);
    op_i(3'b000, 5'd7, 5'd0, 12'h111);
    op_i(3'b000, 5'd8, 5'd0, 12'h222);
    branch(3'b000, 5'd1, 5'd1);
    branch(3'b000, 5'd2, 5'd3);
    branch(3'b001, 5'd2, 5'd3);
    branch(3'b001, 5'd1, 5'd1);
    emit({1'b0, 10'd6, 1'b0, 8'd0, 5'd9, 7'h6f});  // JAL x9, +12
    store(5'd7);
    store(5'd7);
    store(5'd9);
    op_i(3'b000, 5'd0, 5'd0, 12'h5a5);
    store(5'd0);
    emit({20'd0, 5'd0, 7'h6f});
    for (int i = 0; i < 256; i++) ref_mem[i] = mem[i];
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    ref_cycle = 0;
    ref_done  = 1'b0;
    pc = `RESET_PC;
    for (int n = 0; n < 1000 && !ref_done; n++) pc = ref_step(pc);
    limit_cycles = 2 * (ref_cycle + 20);
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    while (exp_addr.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);
    errors += dut.u_decode.u_fsm.u_checker.fail_cnt;
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Each store against the reference queue
  always @(posedge clk) begin
    if (rst_n && mem_we) begin
      if (exp_addr.size() == 0) begin
        $display("Store at %0t to %h was not expected", $time, mem_addr);
        errors++;
      end else begin
        if (mem_addr !== exp_addr[0]) begin
          $display("Mismatch at %0t: mem_addr expected %h got %h", $time, exp_addr[0],
                   mem_addr);
          errors++;
        end
        if (mem_wdata !== exp_data[0]) begin
          $display("Mismatch at %0t: mem_wdata expected %h got %h", $time, exp_data[0],
                   mem_wdata);
          errors++;
        end
        if (cycle_cnt != exp_cycle[0]) begin
          $display("Mismatch at %0t: store cycle expected %0d got %0d", $time,
                   exp_cycle[0], cycle_cnt);
          errors++;
        end
        void'(exp_addr.pop_front());
        void'(exp_data.pop_front());
        void'(exp_cycle.pop_front());
      end
    end
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout, %0d expected stores never happened", exp_addr.size());
    $display("Run finished with %0d errors", errors + 1);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker (
  input logic                    clk,
  input logic                    rst_n,
  input rv_ctrl_pkg::fsm_state_t state,
  input logic                    mem_we,
  input logic                    ir_write
);
  import rv_ctrl_pkg::*;

  int unsigned fail_cnt = 0;

  assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> state == S_MEM_WRITE)
    else begin
      fail_cnt++;
      $error("mem_we high outside S_MEM_WRITE");
    end

  assert property (@(posedge clk) disable iff (!rst_n) ir_write |-> state == S_FETCH)
    else begin
      fail_cnt++;
      $error("ir_write high outside S_FETCH");
    end

  // Decode always follows a fetch
  assert property (@(posedge clk) disable iff (!rst_n)
    state == S_DECODE |-> $past(state) == S_FETCH)
    else begin
      fail_cnt++;
      $error("S_DECODE entered from a state other than S_FETCH");
    end

  assert property (@(posedge clk) $rose(rst_n) |-> state == S_FETCH)
    else begin
      fail_cnt++;
      $error("state is not S_FETCH after reset");
    end

endmodule

bind control_fsm core_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .state    (state),
  .mem_we   (mem_we),
  .ir_write (ir_write)
);

`default_nettype wire

//--- design/rv_multicycle_core.sv
`include "rv_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module rv_multicycle_core (
  input  logic             clk,
  input  logic             rst_n,
  output logic [`XLEN-1:0] mem_addr,
  output logic [`XLEN-1:0] mem_wdata,
  output logic             mem_we,
  input  logic [`XLEN-1:0] mem_rdata
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [`XLEN-1:0] instr;
  logic [`XLEN-1:0] result;
  logic [`XLEN-1:0] rd1;
  logic [`XLEN-1:0] rd2;
  logic [`XLEN-1:0] imm_ext;
  logic             zero;
  logic             pc_write;
  logic             ir_write;
  alu_op_t          alu_op;
  adr_src_t         adr_src;
  src_a_t           src_a;
  src_b_t           src_b;
  result_src_t      result_src;

  datapath u_datapath (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_rdata  (mem_rdata),
    .pc_write   (pc_write),
    .ir_write   (ir_write),
    .adr_src    (adr_src),
    .src_a      (src_a),
    .src_b      (src_b),
    .result_src (result_src),
    .alu_op     (alu_op),
    .rd1        (rd1),
    .rd2        (rd2),
    .imm_ext    (imm_ext),
    .instr      (instr),
    .result     (result),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .zero       (zero)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr      (instr),
    .result     (result),
    .zero       (zero),
    .rd1        (rd1),
    .rd2        (rd2),
    .imm_ext    (imm_ext),
    .alu_op     (alu_op),
    .pc_write   (pc_write),
    .ir_write   (ir_write),
    .mem_we     (mem_we),
    .adr_src    (adr_src),
    .src_a      (src_a),
    .src_b      (src_b),
    .result_src (result_src)
  );

endmodule

`default_nettype wire

//--- design/datapath.sv
`include "rv_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module datapath (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`XLEN-1:0]         mem_rdata,
  input  logic                     pc_write,
  input  logic                     ir_write,
  input  rv_ctrl_pkg::adr_src_t    adr_src,
  input  rv_ctrl_pkg::src_a_t      src_a,
  input  rv_ctrl_pkg::src_b_t      src_b,
  input  rv_ctrl_pkg::result_src_t result_src,
  input  rv_isa_pkg::alu_op_t      alu_op,
  input  logic [`XLEN-1:0]         rd1,
  input  logic [`XLEN-1:0]         rd2,
  input  logic [`XLEN-1:0]         imm_ext,
  output logic [`XLEN-1:0]         instr,
  output logic [`XLEN-1:0]         result,
  output logic [`XLEN-1:0]         mem_addr,
  output logic [`XLEN-1:0]         mem_wdata,
  output logic                     zero
);
  import rv_ctrl_pkg::*;

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] old_pc;
  logic [`XLEN-1:0] data_q;
  logic [`XLEN-1:0] a_q;
  logic [`XLEN-1:0] b_q;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_y;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc    <= `RESET_PC;
      instr <= '0;
    end else begin
      if (pc_write) pc <= result;
      if (ir_write) instr <= mem_rdata;
    end
  end

  // Temporaries load every cycle
  always_ff @(posedge clk) begin
    if (ir_write) old_pc <= pc;
    data_q  <= mem_rdata;
    a_q     <= rd1;
    b_q     <= rd2;
    alu_out <= alu_y;
  end

  assign mem_addr  = (adr_src == ADR_PC) ? pc : alu_out;
  assign mem_wdata = b_q;

  always_comb begin
    case (src_a)
      SRC_A_PC:     alu_a = pc;
      SRC_A_OLD_PC: alu_a = old_pc;
      default:      alu_a = a_q;
    endcase
  end

  always_comb begin
    case (src_b)
      SRC_B_IMM:  alu_b = imm_ext;
      SRC_B_FOUR: alu_b = `XLEN'd4;
      default:    alu_b = b_q;
    endcase
  end

  alu u_alu (
    .a    (alu_a),
    .b    (alu_b),
    .op   (alu_op),
    .y    (alu_y),
    .zero (zero)
  );

  always_comb begin
    case (result_src)
      RES_DATA: result = data_q;
      RES_ALU:  result = alu_y;
      default:  result = alu_out;
    endcase
  end

endmodule

`default_nettype wire

//--- design/alu.sv
`include "rv_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [`XLEN-1:0]    a,
  input  logic [`XLEN-1:0]    b,
  input  rv_isa_pkg::alu_op_t op,
  output logic [`XLEN-1:0]    y,
  output logic                zero
);
  import rv_isa_pkg::*;

  logic lt;

  assign lt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      ALU_ADD:    y = a + b;
      ALU_SUB:    y = a - b;
      ALU_AND:    y = a & b;
      ALU_OR:     y = a | b;
      ALU_XOR:    y = a ^ b;
      ALU_SLT:    y = {{(`XLEN-1){1'b0}}, lt};
      ALU_PASS_B: y = b;
      default:    y = a + b;
    endcase
  end

  assign zero = (y == '0);  // Branch compare

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`include "rv_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`XLEN-1:0]         instr,
  input  logic [`XLEN-1:0]         result,
  input  logic                     zero,
  output logic [`XLEN-1:0]         rd1,
  output logic [`XLEN-1:0]         rd2,
  output logic [`XLEN-1:0]         imm_ext,
  output rv_isa_pkg::alu_op_t      alu_op,
  output logic                     pc_write,
  output logic                     ir_write,
  output logic                     mem_we,
  output rv_ctrl_pkg::adr_src_t    adr_src,
  output rv_ctrl_pkg::src_a_t      src_a,
  output rv_ctrl_pkg::src_b_t      src_b,
  output rv_ctrl_pkg::result_src_t result_src
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  opcode_t            opcode;
  logic [2:0]         funct3;
  logic [`REG_AW-1:0] rd;
  logic [`REG_AW-1:0] rs1;
  logic [`REG_AW-1:0] rs2;
  alu_op_t            dec_alu_op;
  logic               reg_write;
  fsm_state_t         state;

  instr_decoder u_decoder (
    .instr   (instr),
    .opcode  (opcode),
    .funct3  (funct3),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .imm_ext (imm_ext),
    .alu_op  (dec_alu_op)
  );

  reg_file u_reg_file (
    .clk    (clk),
    .rst_n  (rst_n),
    .addr1  (rs1),
    .addr2  (rs2),
    .addr3  (rd),  // IR is stable for the whole instruction
    .we     (reg_write),
    .wdata  (result),
    .rdata1 (rd1),
    .rdata2 (rd2)
  );

  control_fsm u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .opcode     (opcode),
    .funct3     (funct3),
    .zero       (zero),
    .state      (state),
    .pc_write   (pc_write),
    .ir_write   (ir_write),
    .reg_write  (reg_write),
    .mem_we     (mem_we),
    .adr_src    (adr_src),
    .src_a      (src_a),
    .src_b      (src_b),
    .result_src (result_src)
  );

  // PC arithmetic states always add
  assign alu_op = (state == S_FETCH || state == S_DECODE || state == S_JAL) ?
                  ALU_ADD : dec_alu_op;

endmodule

`default_nettype wire

//--- design/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
  input  logic                     clk,
  input  logic                     rst_n,
  input  rv_isa_pkg::opcode_t      opcode,
  input  logic [2:0]               funct3,
  input  logic                     zero,
  output rv_ctrl_pkg::fsm_state_t  state,
  output logic                     pc_write,
  output logic                     ir_write,
  output logic                     reg_write,
  output logic                     mem_we,
  output rv_ctrl_pkg::adr_src_t    adr_src,
  output rv_ctrl_pkg::src_a_t      src_a,
  output rv_ctrl_pkg::src_b_t      src_b,
  output rv_ctrl_pkg::result_src_t result_src
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  fsm_state_t state_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= S_FETCH;
    else        state <= state_next;
  end

  always_comb begin
    state_next = S_FETCH;
    case (state)
      S_FETCH:  state_next = S_DECODE;
      S_DECODE: begin
        case (opcode)
          OP_LOAD, OP_STORE: state_next = S_MEM_ADR;
          OP_REG:            state_next = S_EXEC_R;
          OP_IMM:            state_next = S_EXEC_I;
          OP_BRANCH:         state_next = S_BRANCH;
          OP_JAL:            state_next = S_JAL;
          OP_LUI:            state_next = S_LUI;
          default:           state_next = S_FETCH;  // Unknown opcode acts as a no-op
        endcase
      end
      S_MEM_ADR:  state_next = (opcode == OP_LOAD) ? S_MEM_READ : S_MEM_WRITE;
      S_MEM_READ: state_next = S_MEM_WB;
      S_EXEC_R, S_EXEC_I, S_JAL, S_LUI: state_next = S_ALU_WB;
      default:    state_next = S_FETCH;
    endcase
  end

  // Moore outputs, except the branch decision
  always_comb begin
    pc_write   = 1'b0;
    ir_write   = 1'b0;
    reg_write  = 1'b0;
    mem_we     = 1'b0;
    adr_src    = ADR_PC;
    src_a      = SRC_A_REG;
    src_b      = SRC_B_REG;
    result_src = RES_ALU_OUT;
    case (state)
      S_FETCH: begin
        ir_write   = 1'b1;
        pc_write   = 1'b1;
        src_a      = SRC_A_PC;
        src_b      = SRC_B_FOUR;
        result_src = RES_ALU;  // PC + 4 straight from the ALU
      end
      S_DECODE: begin
        src_a = SRC_A_OLD_PC;  // Branch/jump target
        src_b = SRC_B_IMM;
      end
      S_MEM_ADR: src_b = SRC_B_IMM;
      S_MEM_READ: adr_src = ADR_ALU_OUT;
      S_MEM_WB: begin
        result_src = RES_DATA;
        reg_write  = 1'b1;
      end
      S_MEM_WRITE: begin
        adr_src = ADR_ALU_OUT;
        mem_we  = 1'b1;
      end
      S_EXEC_I: src_b = SRC_B_IMM;
      S_ALU_WB: reg_write = 1'b1;
      S_BRANCH: pc_write = zero ^ funct3[0];  // BEQ on zero, BNE otherwise
      S_JAL: begin
        pc_write = 1'b1;
        src_a    = SRC_A_OLD_PC;  // Link value into ALU-out
        src_b    = SRC_B_FOUR;
      end
      S_LUI: src_b = SRC_B_IMM;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`include "rv_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [`REG_AW-1:0] addr1,
  input  logic [`REG_AW-1:0] addr2,
  input  logic [`REG_AW-1:0] addr3,  // Write port
  input  logic               we,
  input  logic [`XLEN-1:0]   wdata,
  output logic [`XLEN-1:0]   rdata1,
  output logic [`XLEN-1:0]   rdata2
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && addr3 != '0) begin
      regs[addr3] <= wdata;
    end
  end

  // x0 reads as zero
  assign rdata1 = (addr1 == '0) ? '0 : regs[addr1];
  assign rdata2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
`include "rv_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
  input  logic [`XLEN-1:0]    instr,
  output rv_isa_pkg::opcode_t opcode,
  output logic [2:0]          funct3,
  output logic [`REG_AW-1:0]  rd,
  output logic [`REG_AW-1:0]  rs1,
  output logic [`REG_AW-1:0]  rs2,
  output logic [`XLEN-1:0]    imm_ext,
  output rv_isa_pkg::alu_op_t alu_op
);
  import rv_isa_pkg::*;

  imm_fmt_t imm_fmt;
  logic     funct7_b5;

  assign opcode    = opcode_t'(instr[6:0]);
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];  // SUB vs ADD
  assign rd        = instr[11:7];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];

  always_comb begin
    case (opcode)
      OP_STORE:  imm_fmt = IMM_S;
      OP_BRANCH: imm_fmt = IMM_B;
      OP_LUI:    imm_fmt = IMM_U;
      OP_JAL:    imm_fmt = IMM_J;
      default:   imm_fmt = IMM_I;  // Loads and OP-IMM
    endcase
  end

  always_comb begin
    case (imm_fmt)
      IMM_I:   imm_ext = {{20{instr[31]}}, instr[31:20]};
      IMM_S:   imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      IMM_B:   imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      IMM_U:   imm_ext = {instr[31:12], 12'b0};
      IMM_J:   imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm_ext = '0;
    endcase
  end

  always_comb begin
    alu_op = ALU_ADD;  // Loads, stores
    case (opcode)
      OP_REG, OP_IMM: begin
        case (funct3)
          3'b000:  alu_op = (opcode == OP_REG && funct7_b5) ? ALU_SUB : ALU_ADD;
          3'b010:  alu_op = ALU_SLT;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: alu_op = ALU_ADD;
        endcase
      end
      OP_BRANCH: alu_op = ALU_SUB;
      OP_LUI:    alu_op = ALU_PASS_B;
      default:   alu_op = ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    S_FETCH, S_DECODE,
    S_MEM_ADR, S_MEM_READ, S_MEM_WB, S_MEM_WRITE,
    S_EXEC_R, S_EXEC_I, S_ALU_WB,
    S_BRANCH, S_JAL, S_LUI
  } fsm_state_t;

  typedef enum logic {
    ADR_PC,
    ADR_ALU_OUT
  } adr_src_t;

  typedef enum logic [1:0] {
    SRC_A_PC,
    SRC_A_OLD_PC,
    SRC_A_REG
  } src_a_t;

  typedef enum logic [1:0] {
    SRC_B_REG,
    SRC_B_IMM,
    SRC_B_FOUR
  } src_b_t;

  // Result bus also feeds the PC
  typedef enum logic [1:0] {
    RES_ALU_OUT,
    RES_DATA,
    RES_ALU
  } result_src_t;

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_PASS_B = 4'd6  // LUI
  } alu_op_t;

  typedef enum logic [2:0] {
    IMM_I = 3'd0,
    IMM_S = 3'd1,
    IMM_B = 3'd2,
    IMM_U = 3'd3,
    IMM_J = 3'd4
  } imm_fmt_t;

endpackage

`default_nettype wire

//--- design/rv_defines.svh
`default_nettype none

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define XLEN 32

// Architectural registers
`define NUM_REGS 32
`define REG_AW 5

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

`default_nettype wire
